// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rsa
FILELIST  ?= rsa.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "sim passed" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bank_arbiter.sv ====
`timescale 1ns/1ps

module bank_arbiter
  import rsa_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_arst_n,
  // host port
  input  logic      i_host_valid,
  input  bank_req_t i_host_req,
  output logic      o_host_gnt,
  // operand fetch
  input  logic      i_fetch_valid,
  input  bank_req_t i_fetch_req,
  output logic      o_fetch_gnt,
  // result drain
  input  logic      i_drain_valid,
  input  bank_req_t i_drain_req,
  output logic      o_drain_gnt,
  // towards the bank
  output logic      o_bank_en,
  output bank_req_t o_bank_req
);

  // last forwarded access
  bank_req_t hold_q;

  // fixed priority: drain, fetch, host
  always_comb begin
    o_drain_gnt = i_drain_valid;
    o_fetch_gnt = i_fetch_valid && !i_drain_valid;
    o_host_gnt  = i_host_valid && !i_fetch_valid && !i_drain_valid;
    o_bank_en   = i_drain_valid || i_fetch_valid || i_host_valid;
  end

  // request mux
  // idle cycles keep the previous address and data on the bus
  always_comb begin
    if (o_drain_gnt) begin
      o_bank_req = i_drain_req;
    end else if (o_fetch_gnt) begin
      o_bank_req = i_fetch_req;
    end else if (o_host_gnt) begin
      o_bank_req = i_host_req;
    end else begin
      o_bank_req = hold_q;
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      hold_q <= '0;
    end else if (o_bank_en) begin
      hold_q <= o_bank_req;
    end
  end

  // read data goes back to every peer straight from the bank,
  // the granted one takes it a cycle later

endmodule

// ==== operand_fetch.sv ====
`timescale 1ns/1ps

module operand_fetch
  import rsa_pkg::*;
#(
  parameter int X     = 2,
  parameter int Y     = 3,
  parameter int K_MAX = 8
) (
  input  logic             i_clk,
  input  logic             i_arst_n,
  input  logic             i_start,
  input  klen_t            i_k_len,
  output logic             o_done,
  // bank side
  output logic             o_valid,
  output bank_req_t        o_req,
  input  logic             i_gnt,
  input  acc_t             i_rdata,
  // array side
  output logic             o_step_valid,
  output logic             o_step_first,
  output data_t [X-1:0]    o_a_col,
  output data_t [Y-1:0]    o_b_row
);

  // word index within a step, A words first then B words
  localparam int WW = $clog2(X + Y + 1);
  localparam int KW = $clog2(K_MAX + 1);

  // tag of a read in flight, data returns next cycle
  typedef struct packed {
    logic          vld;
    logic [WW-1:0] w;
    logic          first;
    logic          last;
  } ret_t;

  logic               active_q;
  logic [KW-1:0]      k_q;
  logic [WW-1:0]      w_q;
  logic [BANK_AW-1:0] a_off_q;
  logic [BANK_AW-1:0] b_off_q;
  logic               last_word;
  logic               last_step;
  ret_t               ret_q;
  logic               step_valid_q;
  logic               step_first_q;
  logic               done_q;
  data_t [X-1:0]      a_col_q;
  data_t [Y-1:0]      b_row_q;

  assign last_word = (w_q == WW'(X + Y - 1));
  assign last_step = (k_q == KW'(i_k_len - 1'b1));

  // read address from the layout rule
  always_comb begin
    o_valid     = active_q;
    o_req.we    = 1'b0;
    o_req.wdata = '0;
    if (w_q < WW'(X)) begin
      o_req.addr = A_BASE + a_off_q + BANK_AW'(w_q);
    end else begin
      o_req.addr = B_BASE + b_off_q + BANK_AW'(w_q - WW'(X));
    end
  end

  // issue side, one word per grant
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      active_q <= 1'b0;
      k_q      <= '0;
      w_q      <= '0;
      a_off_q  <= '0;
      b_off_q  <= '0;
      ret_q    <= '0;
    end else begin
      ret_q.vld   <= active_q && i_gnt;
      ret_q.w     <= w_q;
      ret_q.first <= (k_q == '0);
      ret_q.last  <= last_step;
      if (i_start) begin
        active_q <= 1'b1;
        k_q      <= '0;
        w_q      <= '0;
        a_off_q  <= '0;
        b_off_q  <= '0;
      end else if (active_q && i_gnt) begin
        if (last_word) begin
          // step complete, move both regions on
          w_q     <= '0;
          k_q     <= k_q + 1'b1;
          a_off_q <= a_off_q + BANK_AW'(X);
          b_off_q <= b_off_q + BANK_AW'(Y);
          if (last_step) begin
            active_q <= 1'b0;
          end
        end else begin
          w_q <= w_q + 1'b1;
        end
      end
    end
  end

  // return side, operand low half into the lane registers
  always_ff @(posedge i_clk) begin
    if (ret_q.vld) begin
      for (int n = 0; n < X; n++) begin
        if (ret_q.w == WW'(n)) begin
          a_col_q[n] <= i_rdata[RSA_DW-1:0];
        end
      end
      for (int n = 0; n < Y; n++) begin
        if (ret_q.w == WW'(X + n)) begin
          b_row_q[n] <= i_rdata[RSA_DW-1:0];
        end
      end
    end
  end

  // step goes out once its last word is in
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      step_valid_q <= 1'b0;
      step_first_q <= 1'b0;
      done_q       <= 1'b0;
    end else begin
      step_valid_q <= ret_q.vld && (ret_q.w == WW'(X + Y - 1));
      step_first_q <= ret_q.vld && (ret_q.w == WW'(X + Y - 1)) && ret_q.first;
      done_q       <= ret_q.vld && (ret_q.w == WW'(X + Y - 1)) && ret_q.last;
    end
  end

  assign o_step_valid = step_valid_q;
  assign o_step_first = step_first_q;
  assign o_a_col      = a_col_q;
  assign o_b_row      = b_row_q;
  assign o_done       = done_q;

endmodule

// ==== pe_array.sv ====
`timescale 1ns/1ps

module pe_array
  import rsa_pkg::*;
#(
  parameter int X = 2,
  parameter int Y = 3
) (
  input  logic            i_clk,
  input  logic            i_arst_n,
  input  logic            i_step_valid,
  input  logic            i_step_first,
  input  data_t [X-1:0]   i_a_col,
  input  data_t [Y-1:0]   i_b_row,
  output acc_t  [X*Y-1:0] o_acc
);

  // a_e[i][j] and flags enter PE(i,j) from the west
  data_t a_e [X][Y+1];
  logic  v_e [X][Y+1];
  logic  f_e [X][Y+1];
  // b_n[i][j] enters PE(i,j) from the south
  data_t b_n [X+1][Y];

  // row skew, row i waits i cycles
  for (genvar i = 0; i < X; i++) begin : g_row
    if (i == 0) begin : g_nd
      assign a_e[i][0] = i_a_col[i];
      assign v_e[i][0] = i_step_valid;
      assign f_e[i][0] = i_step_first;
    end else begin : g_dl
      data_t          a_sr [i];
      logic  [i-1:0]  v_sr;
      logic  [i-1:0]  f_sr;
      always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
          v_sr <= '0;
          f_sr <= '0;
        end else begin
          v_sr[0] <= i_step_valid;
          f_sr[0] <= i_step_first;
          for (int s = 1; s < i; s++) begin
            v_sr[s] <= v_sr[s-1];
            f_sr[s] <= f_sr[s-1];
          end
        end
      end
      always_ff @(posedge i_clk) begin
        a_sr[0] <= i_a_col[i];
        for (int s = 1; s < i; s++) begin
          a_sr[s] <= a_sr[s-1];
        end
      end
      assign a_e[i][0] = a_sr[i-1];
      assign v_e[i][0] = v_sr[i-1];
      assign f_e[i][0] = f_sr[i-1];
    end
  end

  // column skew, column j waits j cycles
  for (genvar j = 0; j < Y; j++) begin : g_col
    if (j == 0) begin : g_nd
      assign b_n[0][j] = i_b_row[j];
    end else begin : g_dl
      data_t b_sr [j];
      always_ff @(posedge i_clk) begin
        b_sr[0] <= i_b_row[j];
        for (int s = 1; s < j; s++) begin
          b_sr[s] <= b_sr[s-1];
        end
      end
      assign b_n[0][j] = b_sr[j-1];
    end
  end

  // PE grid, last column and top row outputs fall off the edge
  for (genvar i = 0; i < X; i++) begin : g_pe_x
    for (genvar j = 0; j < Y; j++) begin : g_pe_y
      pe_mac u_pe_mac (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_valid  (v_e[i][j]),
        .i_first  (f_e[i][j]),
        .i_a      (a_e[i][j]),
        .i_b      (b_n[i][j]),
        .o_valid  (v_e[i][j+1]),
        .o_first  (f_e[i][j+1]),
        .o_a      (a_e[i][j+1]),
        .o_b      (b_n[i+1][j]),
        .o_acc    (o_acc[i*Y+j])
      );
    end
  end

endmodule

// ==== pe_mac.sv ====
`timescale 1ns/1ps

module pe_mac
  import rsa_pkg::*;
(
  input  logic  i_clk,
  input  logic  i_arst_n,
  input  logic  i_valid,
  input  logic  i_first,
  input  data_t i_a,
  input  data_t i_b,
  output logic  o_valid,
  output logic  o_first,
  output data_t o_a,
  output data_t o_b,
  output acc_t  o_acc
);

  acc_t prod;

  // unsigned product, full 32 bits
  assign prod = acc_t'(i_a) * acc_t'(i_b);

  // flags move east with A
  // first step of a stage reloads the accumulator
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid <= 1'b0;
      o_first <= 1'b0;
      o_acc   <= '0;
    end else begin
      o_valid <= i_valid;
      o_first <= i_first;
      if (i_valid) begin
        o_acc <= i_first ? prod : o_acc + prod;
      end
    end
  end

  // A east, B north, one cycle per hop
  always_ff @(posedge i_clk) begin
    o_a <= i_a;
    o_b <= i_b;
  end

endmodule

// ==== result_drain.sv ====
`timescale 1ns/1ps

module result_drain
  import rsa_pkg::*;
#(
  parameter int X = 2,
  parameter int Y = 3
) (
  input  logic           i_clk,
  input  logic           i_arst_n,
  input  logic           i_start,
  input  acc_t [X*Y-1:0] i_acc,
  output logic           o_done,
  output logic           o_valid,
  output bank_req_t      o_req,
  input  logic           i_gnt
);

  localparam int IW = $clog2(X * Y + 1);

  logic          active_q;
  logic [IW-1:0] idx_q;
  logic          last_idx;
  logic          done_q;
  acc_t          acc_sel;

  assign last_idx = (idx_q == IW'(X * Y - 1));

  // pick accumulator i*Y+j
  always_comb begin
    acc_sel = '0;
    for (int n = 0; n < X * Y; n++) begin
      if (idx_q == IW'(n)) begin
        acc_sel = i_acc[n];
      end
    end
  end

  // write into the C region, held until granted
  always_comb begin
    o_valid     = active_q;
    o_req.we    = 1'b1;
    o_req.addr  = C_BASE + BANK_AW'(idx_q);
    o_req.wdata = acc_sel;
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      active_q <= 1'b0;
      idx_q    <= '0;
      done_q   <= 1'b0;
    end else begin
      // done follows the last granted write
      done_q <= active_q && i_gnt && last_idx;
      if (i_start) begin
        active_q <= 1'b1;
        idx_q    <= '0;
      end else if (active_q && i_gnt) begin
        if (last_idx) begin
          active_q <= 1'b0;
        end else begin
          idx_q <= idx_q + 1'b1;
        end
      end
    end
  end

  assign o_done = done_q;

endmodule

// ==== rsa.f ====
rsa_pkg.sv
temp_bank.sv
bank_arbiter.sv
stage_ctrl.sv
operand_fetch.sv
pe_mac.sv
pe_array.sv
result_drain.sv
rsa_top.sv
tb_rsa.sv

// ==== rsa_pkg.sv ====
package rsa_pkg;

  // operand word, low half of a bank word
  localparam int RSA_DW  = 16;
  // accumulator and bank word
  localparam int ACC_DW  = 32;
  // bank address width, 256 words
  localparam int BANK_AW = 8;
  // stage length field, covers 1..8
  localparam int K_LEN_W = 4;

  // region bases inside the temp bank
  // A[i][k] at A_BASE + k*X + i
  localparam logic [BANK_AW-1:0] A_BASE = 8'd0;
  // B[k][j] at B_BASE + k*Y + j
  localparam logic [BANK_AW-1:0] B_BASE = 8'd64;
  // C[i][j] at C_BASE + i*Y + j
  localparam logic [BANK_AW-1:0] C_BASE = 8'd128;

  typedef logic [RSA_DW-1:0]  data_t;
  typedef logic [ACC_DW-1:0]  acc_t;
  typedef logic [K_LEN_W-1:0] klen_t;

  // one bank access, 41 bits
  typedef struct packed {
    logic               we;
    logic [BANK_AW-1:0] addr;
    acc_t               wdata;
  } bank_req_t;

endpackage

// ==== rsa_top.sv ====
`timescale 1ns/1ps

module rsa_top
  import rsa_pkg::*;
#(
  parameter int X     = 2,
  parameter int Y     = 3,
  parameter int K_MAX = 8
) (
  input  logic      clk,
  input  logic      i_arst_n,
  // stage handshake
  input  logic      i_stage_val,
  output logic      o_stage_rdy,
  input  klen_t     i_k_len,
  // host bank port
  input  logic      i_host_valid,
  input  bank_req_t i_host_req,
  output logic      o_host_gnt,
  output acc_t      o_host_rdata
);

  // stage control
  logic fetch_start, fetch_done, drain_start, drain_done;
  klen_t k_len;
  // bank peers
  logic fetch_valid, fetch_gnt, drain_valid, drain_gnt, bank_en;
  bank_req_t fetch_req, drain_req, bank_req;
  acc_t bank_rdata;
  // array feed and results
  logic step_valid, step_first;
  data_t [X-1:0] a_col;
  data_t [Y-1:0] b_row;
  acc_t [X*Y-1:0] acc;

  assign o_host_rdata = bank_rdata;

  stage_ctrl #(.X(X), .Y(Y)) u_stage_ctrl (
    .i_clk (clk), .i_arst_n (i_arst_n),
    .i_stage_val (i_stage_val), .o_stage_rdy (o_stage_rdy), .i_k_len (i_k_len),
    .o_fetch_start (fetch_start), .o_k_len (k_len), .i_fetch_done (fetch_done),
    .o_drain_start (drain_start), .i_drain_done (drain_done)
  );

  bank_arbiter u_bank_arbiter (
    .i_clk (clk), .i_arst_n (i_arst_n),
    .i_host_valid (i_host_valid), .i_host_req (i_host_req), .o_host_gnt (o_host_gnt),
    .i_fetch_valid (fetch_valid), .i_fetch_req (fetch_req), .o_fetch_gnt (fetch_gnt),
    .i_drain_valid (drain_valid), .i_drain_req (drain_req), .o_drain_gnt (drain_gnt),
    .o_bank_en (bank_en), .o_bank_req (bank_req)
  );

  temp_bank u_temp_bank (
    .i_clk (clk), .i_arst_n (i_arst_n),
    .i_en (bank_en), .i_req (bank_req), .o_rdata (bank_rdata)
  );

  operand_fetch #(.X(X), .Y(Y), .K_MAX(K_MAX)) u_operand_fetch (
    .i_clk (clk), .i_arst_n (i_arst_n),
    .i_start (fetch_start), .i_k_len (k_len), .o_done (fetch_done),
    .o_valid (fetch_valid), .o_req (fetch_req), .i_gnt (fetch_gnt), .i_rdata (bank_rdata),
    .o_step_valid (step_valid), .o_step_first (step_first),
    .o_a_col (a_col), .o_b_row (b_row)
  );

  pe_array #(.X(X), .Y(Y)) u_pe_array (
    .i_clk (clk), .i_arst_n (i_arst_n),
    .i_step_valid (step_valid), .i_step_first (step_first),
    .i_a_col (a_col), .i_b_row (b_row), .o_acc (acc)
  );

  result_drain #(.X(X), .Y(Y)) u_result_drain (
    .i_clk (clk), .i_arst_n (i_arst_n),
    .i_start (drain_start), .i_acc (acc), .o_done (drain_done),
    .o_valid (drain_valid), .o_req (drain_req), .i_gnt (drain_gnt)
  );

endmodule

// ==== stage_ctrl.sv ====
`timescale 1ns/1ps

module stage_ctrl
  import rsa_pkg::*;
#(
  parameter int X = 2,
  parameter int Y = 3
) (
  input  logic  i_clk,
  input  logic  i_arst_n,
  // host stage handshake
  input  logic  i_stage_val,
  output logic  o_stage_rdy,
  input  klen_t i_k_len,
  // fetch control
  output logic  o_fetch_start,
  output klen_t o_k_len,
  input  logic  i_fetch_done,
  // drain control
  output logic  o_drain_start,
  input  logic  i_drain_done
);

  localparam int FW = $clog2(X + Y + 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FETCH,
    ST_FLUSH,
    ST_DRAIN
  } state_t;

  state_t        state_q;
  logic [FW-1:0] flush_cnt_q;
  klen_t         k_len_q;
  logic          fetch_start_q;
  logic          drain_start_q;

  // ready only while idle
  assign o_stage_rdy   = (state_q == ST_IDLE);
  assign o_k_len       = k_len_q;
  assign o_fetch_start = fetch_start_q;
  assign o_drain_start = drain_start_q;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q       <= ST_IDLE;
      flush_cnt_q   <= '0;
      k_len_q       <= '0;
      fetch_start_q <= 1'b0;
      drain_start_q <= 1'b0;
    end else begin
      // start strobes last one cycle
      fetch_start_q <= 1'b0;
      drain_start_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          // handshake, k length sampled here
          if (i_stage_val) begin
            k_len_q       <= i_k_len;
            fetch_start_q <= 1'b1;
            state_q       <= ST_FETCH;
          end
        end
        ST_FETCH: begin
          // done comes with the last step
          if (i_fetch_done) begin
            flush_cnt_q <= '0;
            state_q     <= ST_FLUSH;
          end
        end
        ST_FLUSH: begin
          // let the wavefront reach the far corner PE
          if (flush_cnt_q == FW'(X + Y - 1)) begin
            drain_start_q <= 1'b1;
            state_q       <= ST_DRAIN;
          end else begin
            flush_cnt_q <= flush_cnt_q + 1'b1;
          end
        end
        default: begin
          if (i_drain_done) begin
            state_q <= ST_IDLE;
          end
        end
      endcase
    end
  end

endmodule

// ==== tb_rsa.sv ====
`timescale 1ns/1ps

module tb_rsa
  import rsa_pkg::*;
();

  localparam int X            = 2;
  localparam int Y            = 3;
  localparam int K_MAX        = 8;
  localparam int CLK_PERIOD   = 20;
  localparam int NUM_STAGES   = 8;
  // cycle budget per table entry for loads plus stage plus readback
  localparam int STAGE_BUDGET = 300;
  localparam int GNT_LIMIT    = 200;
  localparam int RDY_LIMIT    = 200;

  localparam logic [1:0] MODE_RAND = 2'd0;
  localparam logic [1:0] MODE_ONES = 2'd1;
  localparam logic [1:0] MODE_ZERO = 2'd2;

  // one row of the stage table
  typedef struct packed {
    logic [3:0] k;
    logic [1:0] mode;
    logic       hold_val;
    logic       peek;
  } stage_t;

  logic      clk = 1'b0;
  logic      i_arst_n;
  logic      i_stage_val;
  logic      o_stage_rdy;
  klen_t     i_k_len;
  logic      i_host_valid;
  bank_req_t i_host_req;
  logic      o_host_gnt;
  acc_t      o_host_rdata;

  logic [31:0] rng_q;
  data_t       a_m [X][K_MAX];
  data_t       b_m [K_MAX][Y];
  acc_t        rd_word;

  // k, data mode, hold stage valid, host read during stage
  stage_t stage_tbl [NUM_STAGES] = '{
    '{4'd3, MODE_RAND, 1'b0, 1'b0},
    '{4'd8, MODE_ONES, 1'b0, 1'b0},
    '{4'd1, MODE_RAND, 1'b0, 1'b0},
    '{4'd4, MODE_RAND, 1'b0, 1'b0},
    '{4'd2, MODE_ZERO, 1'b0, 1'b0},
    '{4'd5, MODE_RAND, 1'b0, 1'b1},
    '{4'd8, MODE_RAND, 1'b1, 1'b0},
    '{4'd1, MODE_ONES, 1'b0, 1'b0}
  };

  rsa_top #(
    .X     (X),
    .Y     (Y),
    .K_MAX (K_MAX)
  ) dut_i (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_stage_val  (i_stage_val),
    .o_stage_rdy  (o_stage_rdy),
    .i_k_len      (i_k_len),
    .i_host_valid (i_host_valid),
    .i_host_req   (i_host_req),
    .o_host_gnt   (o_host_gnt),
    .o_host_rdata (o_host_rdata)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic fail_with(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1);
  endtask

  // xorshift32 step
  function automatic logic [31:0] next_rand();
    rng_q = rng_q ^ (rng_q << 13);
    rng_q = rng_q ^ (rng_q >> 17);
    rng_q = rng_q ^ (rng_q << 5);
    return rng_q;
  endfunction

  // sum over k of A[i][k]*B[k][j] wrapping at 32 bits
  function automatic acc_t model_c(input int i, input int j, input int k_len);
    acc_t sum;
    sum = '0;
    for (int k = 0; k < k_len; k++) begin
      sum = sum + acc_t'(a_m[i][k]) * acc_t'(b_m[k][j]);
    end
    return sum;
  endfunction

  // called on a falling edge and returns on the falling edge after the grant
  // read data is taken one cycle after the grant
  task automatic host_access(input logic we, input logic [BANK_AW-1:0] addr,
                             input acc_t wdata, output acc_t rdata);
    int waits;
    waits = 0;
    i_host_req.we    = we;
    i_host_req.addr  = addr;
    i_host_req.wdata = wdata;
    i_host_valid     = 1'b1;
    #1;
    // held until granted
    while (!o_host_gnt) begin
      assert (waits < GNT_LIMIT)
        else fail_with("host request was never granted by the bank arbiter");
      waits++;
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    i_host_valid = 1'b0;
    i_host_req   = '0;
    rdata        = o_host_rdata;
  endtask

  // operand values by mode go to the A and B regions
  task automatic load_operands(input stage_t ent);
    logic [31:0] r;
    acc_t        dummy;
    for (int k = 0; k < int'(ent.k); k++) begin
      for (int i = 0; i < X; i++) begin
        r = next_rand();
        case (ent.mode)
          MODE_ONES: a_m[i][k] = 16'hffff;
          MODE_ZERO: a_m[i][k] = 16'h0000;
          default:   a_m[i][k] = r[15:0];
        endcase
        host_access(1'b1, A_BASE + BANK_AW'(k * X + i), acc_t'(a_m[i][k]), dummy);
      end
      for (int j = 0; j < Y; j++) begin
        r = next_rand();
        case (ent.mode)
          MODE_ONES: b_m[k][j] = 16'hffff;
          MODE_ZERO: b_m[k][j] = 16'h0000;
          default:   b_m[k][j] = r[15:0];
        endcase
        host_access(1'b1, B_BASE + BANK_AW'(k * Y + j), acc_t'(b_m[k][j]), dummy);
      end
    end
  endtask

  task automatic run_stage(input stage_t ent);
    int   waits;
    acc_t peek_word;
    waits = 0;
    i_k_len     = ent.k;
    i_stage_val = 1'b1;
    #1;
    assert (o_stage_rdy)
      else fail_with($sformatf("Error: o_stage_rdy = %h, expected %h at stage offer",
                               o_stage_rdy, 1'b1));
    @(negedge clk);
    assert (!o_stage_rdy)
      else fail_with($sformatf("Error: o_stage_rdy = %h, expected %h after handshake",
                               o_stage_rdy, 1'b0));
    // a held valid stays up through the whole busy period
    if (!ent.hold_val) begin
      i_stage_val = 1'b0;
    end
    if (ent.peek) begin
      // let fetch get going so the host competes for the bank
      repeat (2) @(negedge clk);
      host_access(1'b0, A_BASE, '0, peek_word);
      assert (peek_word === acc_t'(a_m[0][0]))
        else fail_with($sformatf("Error: o_host_rdata during stage = %h, expected %h",
                                 peek_word, acc_t'(a_m[0][0])));
    end
    while (!o_stage_rdy) begin
      assert (waits < RDY_LIMIT)
        else fail_with("stage did not complete, o_stage_rdy stayed low");
      waits++;
      @(negedge clk);
    end
    i_stage_val = 1'b0;
    if (ent.hold_val) begin
      // idle must persist with no hidden second run
      repeat (4) begin
        @(negedge clk);
        assert (o_stage_rdy)
          else fail_with($sformatf("Error: o_stage_rdy = %h, expected %h after held valid",
                                   o_stage_rdy, 1'b1));
      end
    end
  endtask

  // every C word against the model
  task automatic check_results(input stage_t ent);
    acc_t got;
    acc_t exp;
    for (int i = 0; i < X; i++) begin
      for (int j = 0; j < Y; j++) begin
        host_access(1'b0, C_BASE + BANK_AW'(i * Y + j), '0, got);
        exp = model_c(i, j, int'(ent.k));
        assert (got === exp)
          else fail_with($sformatf("Error: C[%0d][%0d] o_host_rdata = %h, expected %h",
                                   i, j, got, exp));
      end
    end
  endtask

  // watchdog sized from the table length
  initial begin
    #((NUM_STAGES * STAGE_BUDGET + 50) * CLK_PERIOD);
    fail_with("watchdog expired before the stage table finished");
  end

  initial begin
    rng_q        = 32'hbfda_617b;
    i_arst_n     = 1'b0;
    i_stage_val  = 1'b0;
    i_k_len      = '0;
    i_host_valid = 1'b0;
    i_host_req   = '0;
    // two rising edges in reset
    repeat (2) @(negedge clk);
    i_arst_n = 1'b1;
    @(negedge clk);

    // idle state after reset
    assert (o_stage_rdy)
      else fail_with($sformatf("Error: o_stage_rdy = %h, expected %h after reset",
                               o_stage_rdy, 1'b1));
    assert (!o_host_gnt)
      else fail_with($sformatf("Error: o_host_gnt = %h, expected %h with no request",
                               o_host_gnt, 1'b0));

    // plain bank write then read at a spare address above C
    host_access(1'b1, 8'd250, 32'hc3a5_5a3c, rd_word);
    host_access(1'b0, 8'd250, '0, rd_word);
    assert (rd_word === 32'hc3a5_5a3c)
      else fail_with($sformatf("Error: o_host_rdata = %h, expected %h",
                               rd_word, 32'hc3a5_5a3c));

    for (int s = 0; s < NUM_STAGES; s++) begin
      load_operands(stage_tbl[s]);
      run_stage(stage_tbl[s]);
      check_results(stage_tbl[s]);
    end

    $display("sim passed");
    $finish;
  end

endmodule

// ==== temp_bank.sv ====
`timescale 1ns/1ps

module temp_bank
  import rsa_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_arst_n,
  input  logic      i_en,
  input  bank_req_t i_req,
  output acc_t      o_rdata
);

  // single port storage, A, B and C regions
  acc_t mem [2**BANK_AW];

  // write port
  always_ff @(posedge i_clk) begin
    if (i_en && i_req.we) begin
      mem[i_req.addr] <= i_req.wdata;
    end
  end

  // registered read, data shows one cycle after the access
  // holds the last read word while idle
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_rdata <= '0;
    end else if (i_en && !i_req.we) begin
      o_rdata <= mem[i_req.addr];
    end
  end

endmodule
